//--- design/aluStage.sv
module aluStage (
	input  logic clk,
	input  logic arstN,
	ctrlIf.alu ctrl,
	input  datapathPkg::wordT bus,
	output datapathPkg::wordT zValue
);

	datapathPkg::wordT y;
	datapathPkg::wordT z;
	datapathPkg::wordT result;

	// Y is the first operand, the bus is the second
	always_comb begin
		case (ctrl.aluOp)
			datapathPkg::aluAdd: result = y + bus;
			datapathPkg::aluSub: result = y - bus;
			datapathPkg::aluAnd: result = y & bus;
			datapathPkg::aluOr: result = y | bus;
			default: begin
				// Fetch step adds one to the PC on the bus
				result = ctrl.incPc ? bus + 1'b1 : bus;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			y <= '0;
			z <= '0;
		end else begin
			if (ctrl.yIn) begin
				y <= bus;
			end
			if (ctrl.zIn) begin
				z <= result;
			end
		end
	end

	assign zValue = z;

endmodule

//--- design/busSelect.sv
module busSelect (
	input  logic clk,
	input  logic arstN,
	ctrlIf.bus ctrl,
	input  datapathPkg::wordT pcValue,
	input  datapathPkg::wordT mdrValue,
	input  datapathPkg::wordT regValue,
	input  datapathPkg::wordT zValue,
	output datapathPkg::wordT bus,
	output datapathPkg::wordT outData,
	output logic outValid
);

	// Only one source is enabled per step
	always_comb begin
		if (ctrl.pcOut) begin
			bus = pcValue;
		end else if (ctrl.mdrOut) begin
			bus = mdrValue;
		end else if (ctrl.zOut) begin
			bus = zValue;
		end else if (ctrl.rOut || ctrl.baOut) begin
			bus = regValue;
		end else if (ctrl.cOut) begin
			bus = ctrl.cSext;
		end else begin
			bus = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.outIn) begin
			outData <= bus;
		end
	end

	// High for the cycle after the out step
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= ctrl.outIn;
		end
	end

endmodule

//--- design/controlSequencer.sv
module controlSequencer (
	input  logic clk,
	input  logic arstN,
	ctrlIf.seq ctrl,
	input  datapathPkg::wordT bus,
	input  logic start,
	output isaPkg::instrU irWord,
	output logic idle,
	output logic halted
);

	datapathPkg::stepT step;
	datapathPkg::stepT nextStep;
	isaPkg::instrU ir;
	isaPkg::opcodeT op;
	logic memOp;
	logic rType;
	logic iType;

	assign op = ir.rFmt.opcode;
	assign memOp = (op == isaPkg::opLd) || (op == isaPkg::opSt);
	assign rType = (op == isaPkg::opAdd) || (op == isaPkg::opSub) ||
		(op == isaPkg::opAnd) || (op == isaPkg::opOr);
	assign iType = (op == isaPkg::opAddi) || (op == isaPkg::opAndi) || (op == isaPkg::opOri);

	// Sign-extended immediate
	assign ctrl.cSext = {
		{(datapathPkg::wordWidth - isaPkg::constWidth){ir.iFmt.c[isaPkg::constWidth-1]}},
		ir.iFmt.c
	};

	always_ff @(posedge clk) begin
		if (ctrl.irIn) begin
			ir <= bus;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			step <= datapathPkg::stepIdle;
		end else begin
			step <= nextStep;
		end
	end

	always_comb begin
		case (step)
			datapathPkg::stepT0: nextStep = datapathPkg::stepT1;
			datapathPkg::stepT1: nextStep = datapathPkg::stepT2;
			datapathPkg::stepT2: nextStep = datapathPkg::stepT3;
			datapathPkg::stepT3: begin
				// halt and unknown opcodes stop here
				if (op == isaPkg::opOut) begin
					nextStep = datapathPkg::stepT0;
				end else if (memOp || rType || iType) begin
					nextStep = datapathPkg::stepT4;
				end else begin
					nextStep = datapathPkg::stepHalted;
				end
			end
			datapathPkg::stepT4: nextStep = datapathPkg::stepT5;
			datapathPkg::stepT5: nextStep = memOp ? datapathPkg::stepT6 : datapathPkg::stepT0;
			datapathPkg::stepT6: nextStep = datapathPkg::stepT7;
			datapathPkg::stepT7: nextStep = datapathPkg::stepT0;
			default: nextStep = start ? datapathPkg::stepT0 : step;
		endcase
	end

	// Strobes of each step
	always_comb begin
		ctrl.pcIn = 1'b0;
		ctrl.marIn = 1'b0;
		ctrl.mdrIn = 1'b0;
		ctrl.irIn = 1'b0;
		ctrl.yIn = 1'b0;
		ctrl.zIn = 1'b0;
		ctrl.rIn = 1'b0;
		ctrl.pcOut = 1'b0;
		ctrl.mdrOut = 1'b0;
		ctrl.zOut = 1'b0;
		ctrl.rOut = 1'b0;
		ctrl.baOut = 1'b0;
		ctrl.cOut = 1'b0;
		ctrl.incPc = 1'b0;
		ctrl.read = 1'b0;
		ctrl.write = 1'b0;
		ctrl.outIn = 1'b0;
		ctrl.gra = 1'b0;
		ctrl.grb = 1'b0;
		ctrl.grc = 1'b0;
		ctrl.aluOp = datapathPkg::aluPassB;
		case (step)
			datapathPkg::stepT0: begin
				ctrl.pcOut = 1'b1;
				ctrl.marIn = 1'b1;
				ctrl.incPc = 1'b1;
				ctrl.zIn = 1'b1;
			end
			datapathPkg::stepT1: begin
				ctrl.zOut = 1'b1;
				ctrl.pcIn = 1'b1;
				ctrl.read = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			datapathPkg::stepT2: begin
				ctrl.mdrOut = 1'b1;
				ctrl.irIn = 1'b1;
			end
			datapathPkg::stepT3: begin
				if (op == isaPkg::opOut) begin
					ctrl.gra = 1'b1;
					ctrl.rOut = 1'b1;
					ctrl.outIn = 1'b1;
				end else if (memOp || rType || iType) begin
					ctrl.grb = 1'b1;
					ctrl.rOut = !memOp;
					ctrl.baOut = memOp;
					ctrl.yIn = 1'b1;
				end
			end
			datapathPkg::stepT4: begin
				ctrl.zIn = 1'b1;
				ctrl.grc = rType;
				ctrl.rOut = rType;
				ctrl.cOut = !rType;
				case (op)
					isaPkg::opSub: ctrl.aluOp = datapathPkg::aluSub;
					isaPkg::opAnd, isaPkg::opAndi: ctrl.aluOp = datapathPkg::aluAnd;
					isaPkg::opOr, isaPkg::opOri: ctrl.aluOp = datapathPkg::aluOr;
					default: ctrl.aluOp = datapathPkg::aluAdd;
				endcase
			end
			datapathPkg::stepT5: begin
				ctrl.zOut = 1'b1;
				ctrl.marIn = memOp;
				ctrl.gra = !memOp;
				ctrl.rIn = !memOp;
			end
			datapathPkg::stepT6: begin
				// ld reads the RAM, st takes the data from ra
				ctrl.mdrIn = 1'b1;
				ctrl.read = (op == isaPkg::opLd);
				ctrl.gra = (op == isaPkg::opSt);
				ctrl.rOut = (op == isaPkg::opSt);
			end
			datapathPkg::stepT7: begin
				ctrl.mdrOut = (op == isaPkg::opLd);
				ctrl.gra = (op == isaPkg::opLd);
				ctrl.rIn = (op == isaPkg::opLd);
				ctrl.write = (op == isaPkg::opSt);
			end
			default: begin
			end
		endcase
	end

	assign irWord = ir;
	// Not running, so the program port may write
	assign idle = (step == datapathPkg::stepIdle) || (step == datapathPkg::stepHalted);
	assign halted = (step == datapathPkg::stepHalted);

endmodule

//--- design/cpuTop.sv
module cpuTop (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  logic progWe,
	input  datapathPkg::addrT progAddr,
	input  datapathPkg::wordT progData,
	output datapathPkg::wordT outData,
	output logic outValid,
	output logic halted
);

	datapathPkg::wordT bus;
	datapathPkg::wordT pcValue;
	datapathPkg::wordT mdrValue;
	datapathPkg::wordT regValue;
	datapathPkg::wordT zValue;
	isaPkg::instrU irWord;
	logic idle;

	ctrlIf ctrlBus ();

	controlSequencer sequencer (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.seq),
		.bus(bus),
		.start(start),
		.irWord(irWord),
		.idle(idle),
		.halted(halted)
	);

	memoryPort memPort (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.mem),
		.bus(bus),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.idle(idle),
		.pcValue(pcValue),
		.mdrValue(mdrValue)
	);

	registerFile regFile (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.regs),
		.irWord(irWord),
		.bus(bus),
		.regValue(regValue)
	);

	aluStage alu (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.alu),
		.bus(bus),
		.zValue(zValue)
	);

	busSelect busMux (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus.bus),
		.pcValue(pcValue),
		.mdrValue(mdrValue),
		.regValue(regValue),
		.zValue(zValue),
		.bus(bus),
		.outData(outData),
		.outValid(outValid)
	);

endmodule

//--- design/ctrlIf.sv
interface ctrlIf;

	// Register load strobes
	logic pcIn;
	logic marIn;
	logic mdrIn;
	logic irIn;
	logic yIn;
	logic zIn;
	logic rIn;

	// Bus source strobes, one at a time
	logic pcOut;
	logic mdrOut;
	logic zOut;
	logic rOut;
	logic baOut;
	logic cOut;

	logic incPc;
	logic read;
	logic write;
	logic outIn;

	datapathPkg::aluOpT aluOp;

	// Which IR field picks the general register
	logic gra;
	logic grb;
	logic grc;

	datapathPkg::wordT cSext;

	modport seq (output pcIn, marIn, mdrIn, irIn, yIn, zIn, rIn, pcOut, mdrOut, zOut,
		rOut, baOut, cOut, incPc, read, write, outIn, aluOp, gra, grb, grc, cSext);
	modport mem (input pcIn, marIn, mdrIn, read, write);
	modport regs (input rIn, baOut, gra, grb, grc);
	modport alu (input yIn, zIn, incPc, aluOp);
	modport bus (input pcOut, mdrOut, zOut, rOut, baOut, cOut, outIn, cSext);

endinterface

//--- design/datapathPkg.sv
package datapathPkg;

	localparam int wordWidth = 32;
	localparam int numRegs = 16;
	localparam int memDepth = 256;
	localparam int addrWidth = 8;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [addrWidth-1:0] addrT;

	// Control steps of the sequencer
	// idle waits for start, halted waits for the next start
	typedef enum logic [3:0] {
		stepIdle,
		stepT0,
		stepT1,
		stepT2,
		stepT3,
		stepT4,
		stepT5,
		stepT6,
		stepT7,
		stepHalted
	} stepT;

	// ALU functions with passB also serving the PC increment
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluPassB
	} aluOpT;

endpackage

//--- design/isaPkg.sv
package isaPkg;

	localparam int opcodeWidth = 5;
	localparam int regIdxWidth = 4;
	localparam int constWidth = 19;
	localparam int unusedWidth = 15;

	// Opcodes of the supported instructions
	// Any value outside this list is executed as halt
	typedef enum logic [opcodeWidth-1:0] {
		opLd   = 5'd0,
		opSt   = 5'd1,
		opAdd  = 5'd2,
		opSub  = 5'd3,
		opAnd  = 5'd4,
		opOr   = 5'd5,
		opAddi = 5'd6,
		opAndi = 5'd7,
		opOri  = 5'd8,
		opOut  = 5'd9,
		opHalt = 5'd10
	} opcodeT;

	typedef logic [regIdxWidth-1:0] regIdxT;

	// Three-register format
	typedef struct packed {
		opcodeT opcode;
		regIdxT ra;
		regIdxT rb;
		regIdxT rc;
		logic [unusedWidth-1:0] unused;
	} rFmtT;

	// Register plus immediate format, also used by ld and st
	typedef struct packed {
		opcodeT opcode;
		regIdxT ra;
		regIdxT rb;
		logic [constWidth-1:0] c;
	} iFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrU;

endpackage

//--- design/memoryPort.sv
module memoryPort (
	input  logic clk,
	input  logic arstN,
	ctrlIf.mem ctrl,
	input  datapathPkg::wordT bus,
	input  logic progWe,
	input  datapathPkg::addrT progAddr,
	input  datapathPkg::wordT progData,
	input  logic idle,
	output datapathPkg::wordT pcValue,
	output datapathPkg::wordT mdrValue
);

	datapathPkg::wordT pc;
	datapathPkg::addrT mar;
	datapathPkg::wordT mdr;
	datapathPkg::wordT ram [datapathPkg::memDepth];
	datapathPkg::wordT ramData;
	logic progLoad;

	// Loads from outside only count while the CPU is not running
	assign progLoad = progWe && idle;

	// Asynchronous read port addressed by MAR
	assign ramData = ram[mar];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (progLoad) begin
			// New program starts from address 0
			pc <= '0;
		end else if (ctrl.pcIn) begin
			pc <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.marIn) begin
			mar <= bus[datapathPkg::addrWidth-1:0];
		end
		if (ctrl.mdrIn) begin
			mdr <= ctrl.read ? ramData : bus;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.write) begin
			ram[mar] <= mdr;
		end else if (progLoad) begin
			ram[progAddr] <= progData;
		end
	end

	assign pcValue = pc;
	assign mdrValue = mdr;

endmodule

//--- design/registerFile.sv
module registerFile (
	input  logic clk,
	input  logic arstN,
	ctrlIf.regs ctrl,
	input  isaPkg::instrU irWord,
	input  datapathPkg::wordT bus,
	output datapathPkg::wordT regValue
);

	datapathPkg::wordT regs [datapathPkg::numRegs];
	isaPkg::regIdxT regIdx;
	logic baseZero;

	// Register index from the IR field chosen by the sequencer
	always_comb begin
		if (ctrl.gra) begin
			regIdx = irWord.rFmt.ra;
		end else if (ctrl.grb) begin
			regIdx = irWord.rFmt.rb;
		end else begin
			regIdx = irWord.rFmt.rc;
		end
	end

	// R0 used as a base reads as zero so ld and st can reach absolute addresses
	assign baseZero = ctrl.baOut && (regIdx == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < datapathPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.rIn) begin
			regs[regIdx] <= bus;
		end
	end

	assign regValue = baseZero ? '0 : regs[regIdx];

endmodule

//--- project.f
design/isaPkg.sv
design/datapathPkg.sv
design/ctrlIf.sv
design/memoryPort.sv
design/registerFile.sv
design/aluStage.sv
design/busSelect.sv
design/controlSequencer.sv
design/cpuTop.sv
sim/cpuTb.sv

//--- sim/cpuTb.sv
module cpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int waitLimit = 200;

	typedef struct {
		string name;
		isaPkg::opcodeT op;
		datapathPkg::wordT a;
		datapathPkg::wordT b;
		logic [isaPkg::constWidth-1:0] imm;
		datapathPkg::wordT expected;
	} caseT;

	logic clk;
	logic arstN;
	logic start;
	logic progWe;
	datapathPkg::addrT progAddr;
	datapathPkg::wordT progData;
	datapathPkg::wordT outData;
	logic outValid;
	logic halted;

	caseT cases[$];
	datapathPkg::wordT prog[$];
	datapathPkg::wordT outs[$];
	integer seed;
	int errors = 0;
	int checks = 0;

	cpuTop UUT (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.outData(outData),
		.outValid(outValid),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Field layout is opcode 31:27, ra 26:23, rb 22:19 and rc 18:15
	function automatic datapathPkg::wordT rInstr(isaPkg::opcodeT op, isaPkg::regIdxT ra,
		isaPkg::regIdxT rb, isaPkg::regIdxT rc);
		return {op, ra, rb, rc, 15'b0};
	endfunction

	function automatic datapathPkg::wordT iInstr(isaPkg::opcodeT op, isaPkg::regIdxT ra,
		isaPkg::regIdxT rb, logic [isaPkg::constWidth-1:0] c);
		return {op, ra, rb, c};
	endfunction

	// Expected result with 32-bit wraparound and a sign-extended constant
	function automatic datapathPkg::wordT refResult(isaPkg::opcodeT op, datapathPkg::wordT a,
		datapathPkg::wordT b, logic [isaPkg::constWidth-1:0] imm);
		datapathPkg::wordT c;
		c = datapathPkg::wordT'($signed(imm));
		case (op)
			isaPkg::opAdd: return a + b;
			isaPkg::opSub: return a - b;
			isaPkg::opAnd: return a & b;
			isaPkg::opOr: return a | b;
			isaPkg::opAddi: return a + c;
			isaPkg::opAndi: return a & c;
			isaPkg::opOri: return a | c;
			default: return '0;
		endcase
	endfunction

	task automatic checkWord(string name, datapathPkg::wordT expected, datapathPkg::wordT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(string name, bit expected, logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic addCase(string name, isaPkg::opcodeT op, datapathPkg::wordT a,
		datapathPkg::wordT b, logic [isaPkg::constWidth-1:0] imm, datapathPkg::wordT expected);
		caseT tc;
		tc.name = name;
		tc.op = op;
		tc.a = a;
		tc.b = b;
		tc.imm = imm;
		tc.expected = expected;
		cases.push_back(tc);
	endtask

	task automatic writeMem(datapathPkg::addrT addr, datapathPkg::wordT data);
		@(negedge clk);
		progWe = 1'b1;
		progAddr = addr;
		progData = data;
		@(negedge clk);
		progWe = 1'b0;
	endtask

	// Program from address 0, then the two data words
	task automatic loadProgram(datapathPkg::wordT d200, datapathPkg::wordT d201);
		foreach (prog[i]) begin
			writeMem(datapathPkg::addrT'(i), prog[i]);
		end
		writeMem(8'd200, d200);
		writeMem(8'd201, d201);
	endtask

	task automatic waitOutValid(string name, output logic found);
		found = 1'b0;
		for (int i = 0; i < waitLimit && !found; i++) begin
			@(negedge clk);
			found = outValid;
		end
		if (!found) begin
			errors++;
			$display("%s: no outValid pulse within %0d cycles", name, waitLimit);
		end
	endtask

	// Any outValid seen here is one pulse too many
	task automatic waitHalted(string name);
		logic done;
		done = 1'b0;
		for (int i = 0; i < waitLimit && !done; i++) begin
			@(negedge clk);
			if (outValid) begin
				errors++;
				$display("%s: outValid pulsed more often than the program has out steps", name);
			end
			done = halted;
		end
		if (!done) begin
			errors++;
			$display("%s: CPU did not halt within %0d cycles", name, waitLimit);
		end
		checkFlag({name, " halted"}, 1'b1, halted);
	endtask

	task automatic runProgram(string name);
		logic found;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		foreach (outs[i]) begin
			waitOutValid(name, found);
			if (found) begin
				checkWord($sformatf("%s out %0d", name, i), outs[i], outData);
			end
		end
		waitHalted(name);
	endtask

	// Operation into R1, then a store and load round trip through address 210
	task automatic runCase(caseT tc);
		logic rType;
		rType = (tc.op == isaPkg::opAdd) || (tc.op == isaPkg::opSub) ||
			(tc.op == isaPkg::opAnd) || (tc.op == isaPkg::opOr);
		prog.delete();
		prog.push_back(iInstr(isaPkg::opLd, 4'd2, 4'd0, 19'd200));
		prog.push_back(iInstr(isaPkg::opLd, 4'd3, 4'd0, 19'd201));
		if (rType) begin
			prog.push_back(rInstr(tc.op, 4'd1, 4'd2, 4'd3));
		end else begin
			prog.push_back(iInstr(tc.op, 4'd1, 4'd2, tc.imm));
		end
		prog.push_back(rInstr(isaPkg::opOut, 4'd1, 4'd0, 4'd0));
		prog.push_back(iInstr(isaPkg::opSt, 4'd1, 4'd0, 19'd210));
		prog.push_back(iInstr(isaPkg::opLd, 4'd4, 4'd0, 19'd210));
		prog.push_back(rInstr(isaPkg::opOut, 4'd4, 4'd0, 4'd0));
		prog.push_back(rInstr(isaPkg::opHalt, 4'd0, 4'd0, 4'd0));
		loadProgram(tc.a, tc.b);
		// Stale word so the store has to happen
		writeMem(8'd210, ~tc.expected);
		outs = '{tc.expected, tc.expected};
		runProgram(tc.name);
	endtask

	initial begin
		datapathPkg::wordT ra;
		datapathPkg::wordT rb;
		logic [isaPkg::constWidth-1:0] rimm;
		seed = 32'hc920589e;
		arstN = 1'b0;
		start = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;

		repeat (8) @(negedge clk);
		checkFlag("reset outValid", 1'b0, outValid);
		checkFlag("reset halted", 1'b0, halted);
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkFlag("after reset outValid", 1'b0, outValid);
		checkFlag("after reset halted", 1'b0, halted);

		// R0 gets a nonzero value and still acts as base zero for ld
		prog.delete();
		prog.push_back(iInstr(isaPkg::opLd, 4'd0, 4'd0, 19'd200));
		prog.push_back(iInstr(isaPkg::opLd, 4'd5, 4'd0, 19'd201));
		prog.push_back(rInstr(isaPkg::opOut, 4'd5, 4'd0, 4'd0));
		prog.push_back(rInstr(isaPkg::opOut, 4'd0, 4'd0, 4'd0));
		prog.push_back(rInstr(isaPkg::opHalt, 4'd0, 4'd0, 4'd0));
		loadProgram(32'h0000_0037, 32'hcafe_0042);
		outs = '{32'hcafe_0042, 32'h0000_0037};
		runProgram("r0 base");

		addCase("add small", isaPkg::opAdd, 32'h5, 32'h3, 19'h0, 32'h0000_0008);
		addCase("add wrap", isaPkg::opAdd, 32'hffff_fff0, 32'h20, 19'h0, 32'h0000_0010);
		addCase("sub borrow", isaPkg::opSub, 32'h3, 32'h5, 19'h0, 32'hffff_fffe);
		addCase("and mask", isaPkg::opAnd, 32'hf0f0_1234, 32'h0ff0_ff00, 19'h0, 32'h00f0_1200);
		addCase("or bits", isaPkg::opOr, 32'h8000_0001, 32'h1100, 19'h0, 32'h8000_1101);
		addCase("addi positive", isaPkg::opAddi, 32'd100, 32'h0, 19'd1234, 32'h0000_0536);
		addCase("addi minus one", isaPkg::opAddi, 32'd100, 32'h0, 19'h7ffff, 32'h0000_0063);
		addCase("andi negative", isaPkg::opAndi, 32'h1234_5678, 32'h0, 19'h40000, 32'h1234_0000);
		addCase("ori positive", isaPkg::opOri, 32'h1000_0000, 32'h0, 19'h00abc, 32'h1000_0abc);
		addCase("ori negative", isaPkg::opOri, 32'h11, 32'h0, 19'h7ff00, 32'hffff_ff11);
		ra = $random(seed);
		rb = $random(seed);
		addCase("add random", isaPkg::opAdd, ra, rb, 19'h0, refResult(isaPkg::opAdd, ra, rb, '0));
		ra = $random(seed);
		rb = $random(seed);
		addCase("sub random", isaPkg::opSub, ra, rb, 19'h0, refResult(isaPkg::opSub, ra, rb, '0));
		ra = $random(seed);
		rimm = 19'($random(seed));
		addCase("andi random", isaPkg::opAndi, ra, 32'h0, rimm,
			refResult(isaPkg::opAndi, ra, '0, rimm));

		foreach (cases[i]) begin
			runCase(cases[i]);
		end

		// Opcode 31 is not defined and must halt before the out behind it
		prog.delete();
		prog.push_back(32'hf800_0000);
		prog.push_back(rInstr(isaPkg::opOut, 4'd1, 4'd0, 4'd0));
		loadProgram(32'h0, 32'h0);
		outs.delete();
		runProgram("unknown opcode");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
